//--- hw/csr_pkg.sv
// Shared definitions for the machine-mode CSR bank.
// Holds the CSR address map, access operations, privilege levels,
// trap cause codes, write masks and the mstatus layout.
// Modules refer to these by scoped names.

`default_nettype none

package csr_pkg;

    localparam int unsigned XLEN = 32;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,     // User aliases, read only
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,     // Identity, reads zero
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTRUCTION_MISALIGNED   = 5'd0,
        INSTRUCTION_ACCESS_FAULT = 5'd1,
        ILLEGAL_INSTRUCTION      = 5'd2,
        BREAKPOINT               = 5'd3,
        LOAD_MISALIGNED          = 5'd4,
        LOAD_ACCESS_FAULT        = 5'd5,
        STORE_MISALIGNED         = 5'd6,
        STORE_ACCESS_FAULT       = 5'd7,
        ECALL_FROM_UMODE         = 5'd8,
        ECALL_FROM_MMODE         = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    //////////////////////////////////////////////////////////////////////
    // Write masks and constants
    //////////////////////////////////////////////////////////////////////

    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h007E19AA;
    localparam logic [XLEN-1:0] MIE_MASK     = 32'h00000888;
    localparam logic [XLEN-1:0] ALIGN_MASK   = 32'hFFFFFFFC;   // mtvec, mepc
    localparam logic [XLEN-1:0] FULL_MASK    = 32'hFFFFFFFF;
    localparam logic [XLEN-1:0] RO_MASK      = 32'h00000000;

    // MXL=1, U, M and I
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h40101100;

    localparam int unsigned MIE_BIT  = 3;   // mstatus global enable
    localparam int unsigned MSIP_BIT = 3;
    localparam int unsigned MTIP_BIT = 7;
    localparam int unsigned MEIP_BIT = 11;

    //////////////////////////////////////////////////////////////////////
    // mstatus layout
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       sd;
        logic [7:0] res_hi;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;          // Not implemented
        logic       sum;
        logic       mprv;         // Not implemented
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] vs;
        logic       spp;          // No supervisor mode
        logic       mpie;
        logic       ube;
        logic       spie;
        logic       res_4;
        logic       mie;
        logic       res_2;
        logic       sie;
        logic       res_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [XLEN-1:0] word;
        mstatus_fields_t fields;
    } mstatus_u;

endpackage

`default_nettype wire

//--- hw/csr_access.sv
// CSR access unit.
// Picks the current value of the addressed register from its owner,
// applies the write mask and the write/set/clear operation, decides
// whether a write may happen, and gates the read data.

`default_nettype none
`timescale 1ns/100ps

module csr_access (
    input  wire csr_pkg::csr_addr_e        address_i,
    input  wire csr_pkg::csr_op_e          operation_i,
    input  wire logic [csr_pkg::XLEN-1:0]  data_i,
    input  wire logic                      read_enable_i,
    input  wire logic                      write_enable_i,
    input  wire logic                      killed_i,
    input  wire logic                      raise_exception_i,
    input  wire logic                      machine_return_i,
    input  wire logic                      interrupt_ack_i,
    input  wire logic [csr_pkg::XLEN-1:0]  machine_cur_i,
    input  wire logic [csr_pkg::XLEN-1:0]  counter_cur_i,
    output logic                           wr_en_o,
    output logic      [csr_pkg::XLEN-1:0]  wr_data_o,
    output logic      [csr_pkg::XLEN-1:0]  rdata_o
);

    logic [csr_pkg::XLEN-1:0] cur_val, wmask, masked_data;
    logic                     read_allowed;

    //////////////////////////////////////////////////////////////////////
    // Ownership and masks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (address_i)
            csr_pkg::MSTATUS: begin
                cur_val = machine_cur_i;
                wmask   = csr_pkg::MSTATUS_MASK;
            end
            csr_pkg::MIE: begin
                cur_val = machine_cur_i;
                wmask   = csr_pkg::MIE_MASK;
            end
            csr_pkg::MTVEC, csr_pkg::MEPC: begin
                cur_val = machine_cur_i;
                wmask   = csr_pkg::ALIGN_MASK;
            end
            csr_pkg::MSCRATCH, csr_pkg::MCAUSE, csr_pkg::MTVAL: begin
                cur_val = machine_cur_i;
                wmask   = csr_pkg::FULL_MASK;
            end
            csr_pkg::MISA, csr_pkg::MIP: begin
                cur_val = machine_cur_i;
                wmask   = csr_pkg::RO_MASK;
            end
            csr_pkg::MCYCLE, csr_pkg::MCYCLEH,
            csr_pkg::MINSTRET, csr_pkg::MINSTRETH: begin
                cur_val = counter_cur_i;
                wmask   = csr_pkg::FULL_MASK;
            end
            csr_pkg::CYCLE, csr_pkg::CYCLEH,
            csr_pkg::INSTRET, csr_pkg::INSTRETH: begin
                cur_val = counter_cur_i;        // User view, no writes
                wmask   = csr_pkg::RO_MASK;
            end
            default: begin                      // Identity regs and unknown
                cur_val = '0;
                wmask   = csr_pkg::RO_MASK;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Operation and permissions
    //////////////////////////////////////////////////////////////////////

    assign masked_data = data_i & wmask;

    always_comb begin
        case (operation_i)
            csr_pkg::CSR_SET:   wr_data_o = cur_val | masked_data;
            csr_pkg::CSR_CLEAR: wr_data_o = cur_val & ~masked_data;
            default:            wr_data_o = masked_data;
        endcase
    end

    // Any trap in the same cycle wins over the write
    assign wr_en_o = write_enable_i && !killed_i && !raise_exception_i
                     && !machine_return_i && !interrupt_ack_i;

    assign read_allowed = read_enable_i && !killed_i;
    assign rdata_o      = read_allowed ? cur_val : '0;

endmodule

`default_nettype wire

//--- hw/csr_counters.sv
// 64-bit mcycle and minstret counters.
// mcycle counts every edge, minstret only when the instruction is not
// killed. A write to one half replaces that half's increment.

`default_nettype none
`timescale 1ns/100ps

module csr_counters (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire csr_pkg::csr_addr_e        address_i,
    input  wire logic                      wr_en_i,
    input  wire logic [csr_pkg::XLEN-1:0]  wr_data_i,
    input  wire logic                      killed_i,
    output logic      [csr_pkg::XLEN-1:0]  cur_o
);

    logic [63:0] mcycle, minstret;

    function automatic logic [63:0] next_count(input logic [63:0] cnt,
                                               input logic        inc,
                                               input logic        wr_lo,
                                               input logic        wr_hi,
                                               input logic [31:0] data);
        logic [63:0] sum;
        sum = cnt + {63'b0, inc};
        if (wr_lo)
            sum[31:0] = data;
        if (wr_hi)
            sum[63:32] = data;
        return sum;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= next_count(mcycle, 1'b1,
                                   wr_en_i && address_i == csr_pkg::MCYCLE,
                                   wr_en_i && address_i == csr_pkg::MCYCLEH, wr_data_i);
            minstret <= next_count(minstret, !killed_i,
                                   wr_en_i && address_i == csr_pkg::MINSTRET,
                                   wr_en_i && address_i == csr_pkg::MINSTRETH, wr_data_i);
        end
    end

    // Machine and user names read the same halves
    always_comb begin
        case (address_i)
            csr_pkg::MCYCLE,    csr_pkg::CYCLE:    cur_o = mcycle[31:0];
            csr_pkg::MCYCLEH,   csr_pkg::CYCLEH:   cur_o = mcycle[63:32];
            csr_pkg::MINSTRET,  csr_pkg::INSTRET:  cur_o = minstret[31:0];
            csr_pkg::MINSTRETH, csr_pkg::INSTRETH: cur_o = minstret[63:32];
            default:                               cur_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/csr_machine_regs.sv
// Machine trap registers and the current privilege level.
// Handles exception entry, interrupt entry and mret, and raises
// interrupt_pending_o two edges after an enabled irq line goes high.

`default_nettype none
`timescale 1ns/100ps

module csr_machine_regs (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire csr_pkg::csr_addr_e        address_i,
    input  wire logic                      wr_en_i,
    input  wire logic [csr_pkg::XLEN-1:0]  wr_data_i,
    input  wire logic                      raise_exception_i,
    input  wire logic                      machine_return_i,
    input  wire logic                      interrupt_ack_i,
    input  wire csr_pkg::exc_code_e        exception_code_i,
    input  wire logic [csr_pkg::XLEN-1:0]  pc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  instruction_i,
    input  wire logic [csr_pkg::XLEN-1:0]  irq_i,
    output logic      [csr_pkg::XLEN-1:0]  cur_o,
    output csr_pkg::priv_e                 privilege_o,
    output logic      [csr_pkg::XLEN-1:0]  mepc_o,
    output logic      [csr_pkg::XLEN-1:0]  mtvec_o,
    output logic                           interrupt_pending_o
);

    csr_pkg::mstatus_u  mstatus;
    csr_pkg::mstatus_u  wr_status;
    csr_pkg::priv_e     privilege;
    csr_pkg::irq_code_e irq_cause;

    logic [csr_pkg::XLEN-1:0] mie, mip, mtvec, mscratch, mepc, mcause, mtval;
    logic [csr_pkg::XLEN-1:0] irq_active;
    logic                     global_ie;

    assign privilege_o = privilege;
    assign mepc_o      = mepc;
    assign mtvec_o     = mtvec;

    // Write data seen as mstatus, unimplemented bits forced low
    always_comb begin
        wr_status.word          = wr_data_i;
        wr_status.fields.res_hi = '0;
        wr_status.fields.mxr    = 1'b0;
        wr_status.fields.mprv   = 1'b0;
        wr_status.fields.spp    = 1'b0;
        wr_status.fields.res_4  = 1'b0;
        wr_status.fields.res_2  = 1'b0;
        wr_status.fields.res_0  = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Register updates, return > exception > interrupt > write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus.word <= '0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            privilege    <= csr_pkg::PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus.fields.mie <= mstatus.fields.mpie;
            privilege          <= csr_pkg::priv_e'(mstatus.fields.mpp);
        end else if (raise_exception_i) begin
            mepc                <= pc_i;
            mcause              <= {27'b0, exception_code_i};
            mtval               <= (exception_code_i == csr_pkg::ILLEGAL_INSTRUCTION)
                                   ? instruction_i : pc_i;
            mstatus.fields.mpie <= mstatus.fields.mie;
            mstatus.fields.mie  <= 1'b0;
            mstatus.fields.mpp  <= privilege;
            privilege           <= csr_pkg::PRIV_MACHINE;
        end else if (interrupt_ack_i) begin
            mepc                <= pc_i;                      // mtval left alone
            mcause              <= {1'b1, 26'b0, irq_cause};
            mstatus.fields.mpie <= mstatus.fields.mie;
            mstatus.fields.mie  <= 1'b0;
            mstatus.fields.mpp  <= privilege;
            privilege           <= csr_pkg::PRIV_MACHINE;
        end else if (wr_en_i) begin
            case (address_i)
                csr_pkg::MSTATUS:  mstatus  <= wr_status;
                csr_pkg::MIE:      mie      <= wr_data_i;
                csr_pkg::MTVEC:    mtvec    <= wr_data_i;
                csr_pkg::MSCRATCH: mscratch <= wr_data_i;
                csr_pkg::MEPC:     mepc     <= wr_data_i;
                csr_pkg::MCAUSE:   mcause   <= wr_data_i;
                csr_pkg::MTVAL:    mtval    <= wr_data_i;
                default: ;                                      // Not ours or read only
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupt detection
    //////////////////////////////////////////////////////////////////////

    assign global_ie  = mstatus.word[csr_pkg::MIE_BIT];
    assign irq_active = mie & mip;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip                 <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip                 <= irq_i;
            interrupt_pending_o <= global_ie && (irq_active != '0) && !interrupt_ack_i;
        end
    end

    // Cause latched alongside pending, external first
    always_ff @(posedge clk) begin
        if (global_ie && (irq_active != '0) && !interrupt_ack_i) begin
            if (irq_active[csr_pkg::MEIP_BIT])
                irq_cause <= csr_pkg::M_EXT_INT;
            else if (irq_active[csr_pkg::MSIP_BIT])
                irq_cause <= csr_pkg::M_SW_INT;
            else
                irq_cause <= csr_pkg::M_TIM_INT;
        end
    end

    // Current value of the addressed register, zero if not owned here
    always_comb begin
        case (address_i)
            csr_pkg::MSTATUS:  cur_o = mstatus.word;
            csr_pkg::MISA:     cur_o = csr_pkg::MISA_VALUE;
            csr_pkg::MIE:      cur_o = mie;
            csr_pkg::MTVEC:    cur_o = mtvec;
            csr_pkg::MSCRATCH: cur_o = mscratch;
            csr_pkg::MEPC:     cur_o = mepc;
            csr_pkg::MCAUSE:   cur_o = mcause;
            csr_pkg::MTVAL:    cur_o = mtval;
            csr_pkg::MIP:      cur_o = mip;
            default:           cur_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/csr_bank.sv
// Top level of the machine-mode CSR bank.
// The access unit feeds masked write data to the trap registers and
// the counters, and builds read data from their current values.

`default_nettype none
`timescale 1ns/100ps

module csr_bank (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire csr_pkg::csr_addr_e        address_i,
    input  wire csr_pkg::csr_op_e          operation_i,
    input  wire logic [csr_pkg::XLEN-1:0]  data_i,
    input  wire logic                      read_enable_i,
    input  wire logic                      write_enable_i,
    input  wire logic                      killed_i,
    input  wire logic                      raise_exception_i,
    input  wire logic                      machine_return_i,
    input  wire logic                      interrupt_ack_i,
    input  wire csr_pkg::exc_code_e        exception_code_i,
    input  wire logic [csr_pkg::XLEN-1:0]  pc_i,
    input  wire logic [csr_pkg::XLEN-1:0]  instruction_i,
    input  wire logic [csr_pkg::XLEN-1:0]  irq_i,
    output logic      [csr_pkg::XLEN-1:0]  rdata_o,
    output csr_pkg::priv_e                 privilege_o,
    output logic      [csr_pkg::XLEN-1:0]  mepc_o,
    output logic      [csr_pkg::XLEN-1:0]  mtvec_o,
    output logic                           interrupt_pending_o
);

    logic                     wr_en;
    logic [csr_pkg::XLEN-1:0] wr_data, machine_cur, counter_cur;

    csr_access u_access (
        .address_i         (address_i),
        .operation_i       (operation_i),
        .data_i            (data_i),
        .read_enable_i     (read_enable_i),
        .write_enable_i    (write_enable_i),
        .killed_i          (killed_i),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .machine_cur_i     (machine_cur),
        .counter_cur_i     (counter_cur),
        .wr_en_o           (wr_en),
        .wr_data_o         (wr_data),
        .rdata_o           (rdata_o)
    );

    csr_machine_regs u_machine_regs (
        .clk                 (clk),
        .reset_n             (reset_n),
        .address_i           (address_i),
        .wr_en_i             (wr_en),
        .wr_data_i           (wr_data),
        .raise_exception_i   (raise_exception_i),
        .machine_return_i    (machine_return_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .exception_code_i    (exception_code_i),
        .pc_i                (pc_i),
        .instruction_i       (instruction_i),
        .irq_i               (irq_i),
        .cur_o               (machine_cur),
        .privilege_o         (privilege_o),
        .mepc_o              (mepc_o),
        .mtvec_o             (mtvec_o),
        .interrupt_pending_o (interrupt_pending_o)
    );

    csr_counters u_counters (
        .clk       (clk),
        .reset_n   (reset_n),
        .address_i (address_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .killed_i  (killed_i),
        .cur_o     (counter_cur)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source.
// 40 ns clock period, reset_n held low for the first 16 cycles.

`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;                       // Released away from the rising edge
    end

endmodule

`default_nettype wire

//--- sim/csr_bank_props.sv
// Concurrent checks on trap entry, mret and the interrupt handshake.
// Bound into every csr_machine_regs instance by the bind at the end.

`default_nettype none
`timescale 1ns/100ps

module csr_bank_props (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire logic                      raise_exception_i,
    input  wire logic                      machine_return_i,
    input  wire logic                      interrupt_ack_i,
    input  wire logic                      interrupt_pending_i,
    input  wire logic [csr_pkg::XLEN-1:0]  mstatus_i,
    input  wire logic [1:0]                privilege_i
);

    // Exception entry clears the global enable, unless mret wins
    exception_clears_mie: assert property (
        @(posedge clk) disable iff (!reset_n)
        raise_exception_i && !machine_return_i |=> !mstatus_i[csr_pkg::MIE_BIT]
    ) else $error("mstatus.mie still set after exception entry");

    ack_drops_pending: assert property (
        @(posedge clk) disable iff (!reset_n)
        interrupt_ack_i |=> !interrupt_pending_i
    ) else $error("interrupt pending high in the cycle after an acknowledge");

    // mpp sits at mstatus[12:11]
    mret_restores_privilege: assert property (
        @(posedge clk) disable iff (!reset_n)
        machine_return_i |=> privilege_i == $past(mstatus_i[12:11])
    ) else $error("privilege after mret differs from the previous mpp");

endmodule

bind csr_machine_regs csr_bank_props u_props (
    .clk                 (clk),
    .reset_n             (reset_n),
    .raise_exception_i   (raise_exception_i),
    .machine_return_i    (machine_return_i),
    .interrupt_ack_i     (interrupt_ack_i),
    .interrupt_pending_i (interrupt_pending_o),
    .mstatus_i           (mstatus.word),
    .privilege_i         (privilege)
);

`default_nettype wire

//--- sim/csr_bank_tb.sv
// Testbench for the CSR bank.
// Reads commands from sim/csr_bank_input.txt, drives the DUT on falling
// edges and samples its outputs a quarter period later.
// Command kinds: R read, W write, K killed write, N idle, C/H counter
// deltas, E exception, X mret, P privilege, I irq lines, A acknowledge.

`default_nettype none
`timescale 1ns/100ps

module csr_bank_tb;

    localparam int    WAIT_LIMIT   = 40;      // Cycles allowed for any polled wait
    localparam int    SAMPLE_DELAY = 10;      // After the falling edge
    localparam string VECTOR_FILE  = "sim/csr_bank_input.txt";

    logic               clk, reset_n;
    csr_pkg::csr_addr_e address;
    csr_pkg::csr_op_e   operation;
    csr_pkg::exc_code_e exception_code;
    csr_pkg::priv_e     privilege;
    logic [31:0]        data, pc, instruction, irq;
    logic [31:0]        rdata, mepc, mtvec;
    logic               read_enable, write_enable, killed;
    logic               raise_exception, machine_return, interrupt_ack;
    logic               interrupt_pending;

    tb_clock_gen u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    csr_bank dut0 (
        .clk                 (clk),
        .reset_n             (reset_n),
        .address_i           (address),
        .operation_i         (operation),
        .data_i              (data),
        .read_enable_i       (read_enable),
        .write_enable_i      (write_enable),
        .killed_i            (killed),
        .raise_exception_i   (raise_exception),
        .machine_return_i    (machine_return),
        .interrupt_ack_i     (interrupt_ack),
        .exception_code_i    (exception_code),
        .pc_i                (pc),
        .instruction_i       (instruction),
        .irq_i               (irq),
        .rdata_o             (rdata),
        .privilege_o         (privilege),
        .mepc_o              (mepc),
        .mtvec_o             (mtvec),
        .interrupt_pending_o (interrupt_pending)
    );

    //////////////////////////////////////////////////////////////////////
    // Basic helpers
    //////////////////////////////////////////////////////////////////////

    function automatic csr_pkg::csr_addr_e to_addr(input logic [31:0] field);
        return csr_pkg::csr_addr_e'(field[11:0]);
    endfunction

    // Per-cycle controls back to idle, irq/pc/instruction persist
    task automatic clear_inputs();
        address         = csr_pkg::MVENDORID;
        operation       = csr_pkg::CSR_WRITE;
        data            = '0;
        read_enable     = 1'b0;
        write_enable    = 1'b0;
        killed          = 1'b0;
        raise_exception = 1'b0;
        machine_return  = 1'b0;
        interrupt_ack   = 1'b0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic settle();
        #SAMPLE_DELAY;
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %08h, expected %08h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (reset_n !== 1'b1) begin
            if (waited >= WAIT_LIMIT)
                fail_run("reset_n was never released");
            else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Commands
    //////////////////////////////////////////////////////////////////////

    task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected);
        next_cycle();
        address     = to_addr(addr);
        read_enable = 1'b1;
        settle();
        check_value($sformatf("read of CSR %03h", addr[11:0]), rdata, expected);
        if (address == csr_pkg::MTVEC)
            check_value("mtvec_o", mtvec, expected);    // Trap vector has its own port
    endtask

    task automatic write_csr(input logic [31:0] addr, input logic [31:0] op,
                             input logic [31:0] value, input logic kill);
        next_cycle();
        address      = to_addr(addr);
        operation    = csr_pkg::csr_op_e'(op[1:0]);
        data         = value;
        write_enable = 1'b1;
        killed       = kill;
    endtask

    // Reads addr_a, then addr_b the given number of cycles later
    task automatic measure_counter(input logic [31:0] addr_a, input logic [31:0] cycles,
                                   input logic [31:0] addr_b, input logic kill_between,
                                   input logic [31:0] expected);
        logic [31:0] first;
        next_cycle();
        address     = to_addr(addr_a);
        read_enable = 1'b1;
        settle();
        first = rdata;
        repeat (cycles - 1) begin
            next_cycle();
            killed = kill_between;
        end
        next_cycle();
        address     = to_addr(addr_b);
        read_enable = 1'b1;
        settle();
        check_value("counter difference", rdata - first, expected);
    endtask

    task automatic raise_trap(input logic [31:0] code, input logic [31:0] pc_value,
                              input logic [31:0] instr);
        next_cycle();
        raise_exception = 1'b1;
        exception_code  = csr_pkg::exc_code_e'(code[4:0]);
        pc              = pc_value;
        instruction     = instr;
    endtask

    task automatic check_privilege(input logic [31:0] expected);
        next_cycle();
        settle();
        check_value("privilege_o", {30'b0, privilege}, expected);
    endtask

    task automatic return_and_check(input logic [31:0] expected);
        next_cycle();
        machine_return = 1'b1;
        check_privilege(expected);
    endtask

    // Sets irq lines, then polls pending until it goes high.
    // A low expectation is checked at once, before the new lines reach pending
    task automatic drive_irq(input logic [31:0] lines, input logic [31:0] expected);
        int waited;
        next_cycle();
        irq = lines;
        settle();
        if (expected[0] == 1'b0) begin
            check_value("interrupt_pending_o", {31'b0, interrupt_pending}, expected);
        end else begin
            waited = 0;
            while (interrupt_pending !== expected[0]) begin
                if (waited >= WAIT_LIMIT)
                    fail_run("interrupt_pending_o did not reach the expected level in time");
                else begin
                    next_cycle();
                    settle();
                    waited++;
                end
            end
        end
    endtask

    task automatic acknowledge_irq(input logic [31:0] pc_value, input logic [31:0] expected);
        next_cycle();
        interrupt_ack = 1'b1;
        pc            = pc_value;
        next_cycle();
        settle();
        check_value("interrupt_pending_o after ack", {31'b0, interrupt_pending}, expected);
        check_value("mepc_o after ack", mepc, pc_value);
    endtask

    task automatic run_command(input logic [7:0] kind, input logic [31:0] f_addr,
                               input logic [31:0] f_op, input logic [31:0] f_data,
                               input logic [31:0] f_exp);
        case (kind)
            "R": read_and_check(f_addr, f_exp);
            "W": write_csr(f_addr, f_op, f_data, 1'b0);
            "K": write_csr(f_addr, f_op, f_data, 1'b1);
            "N": repeat (f_data) next_cycle();
            "C": measure_counter(f_addr, f_op, f_data, 1'b0, f_exp);
            "H": measure_counter(f_addr, f_op, f_data, 1'b1, f_exp);
            "E": raise_trap(f_op, f_data, f_exp);
            "X": return_and_check(f_exp);
            "P": check_privilege(f_exp);
            "I": drive_irq(f_data, f_exp);
            "A": acknowledge_irq(f_data, f_exp);
            default: fail_run($sformatf("Unknown command kind '%c' in the vector file", kind));
        endcase
    endtask

    task automatic run_vectors(input int fd);
        string       line;
        logic [7:0]  kind;
        logic [31:0] f_addr, f_op, f_data, f_exp;
        int          count, line_no;
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                       // Blank or comment
            count = $sscanf(line, "%c %h %h %h %h", kind, f_addr, f_op, f_data, f_exp);
            if (count != 5)
                fail_run($sformatf("Line %0d of the vector file could not be parsed",
                                   line_no));
            else
                run_command(kind, f_addr, f_op, f_data, f_exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        int fd;
        clear_inputs();
        exception_code = csr_pkg::ILLEGAL_INSTRUCTION;
        pc             = '0;
        instruction    = '0;
        irq            = '0;
        wait_for_reset();
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the vector file sim/csr_bank_input.txt");
        end else begin
            run_vectors(fd);
            $fclose(fd);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/csr_bank_input.txt
# kind addr(hex) op(hex) data(hex) expected(hex); op 1=write 2=set 3=clear
# C/H: op=cycles apart, data=second address; E: op=code, data=pc, expected=instr
P 000 00 00000000 00000003
R 300 00 00000000 00000000
R 341 00 00000000 00000000
R 344 00 00000000 00000000
R 301 00 00000000 40101100
W 305 01 FFFFFFFF 00000000
R 305 00 00000000 FFFFFFFC
W 304 01 FFFFFFFF 00000000
R 304 00 00000000 00000888
W 300 01 FFFFFFFF 00000000
R 300 00 00000000 007418AA
W 301 01 FFFFFFFF 00000000
R 301 00 00000000 40101100
R 7C0 00 00000000 00000000
R F11 00 00000000 00000000
R F14 00 00000000 00000000
W 340 01 12345678 00000000
W 340 02 0000F000 00000000
R 340 00 00000000 1234F678
W 340 03 12000008 00000000
R 340 00 00000000 0034F670
W 304 03 00000800 00000000
R 304 00 00000000 00000088
W 304 02 00000FFF 00000000
R 304 00 00000000 00000888
K 340 01 DEADBEEF 00000000
R 340 00 00000000 0034F670
C B00 0A 00000B00 0000000A
W B00 01 00001000 00000000
N 000 00 00000003 00000000
R B00 00 00000000 00001003
C B00 01 00000C00 00000001
C B02 01 00000C02 00000001
H B02 05 00000B02 00000001
W 300 03 00000080 00000000
R 300 00 00000000 0074182A
E 000 02 00000400 00C0FFEE
R 341 00 00000000 00000400
R 343 00 00000000 00C0FFEE
R 342 00 00000000 00000002
R 300 00 00000000 007418A2
P 000 00 00000000 00000003
W 300 03 00001800 00000000
R 300 00 00000000 007400A2
X 000 00 00000000 00000000
R 300 00 00000000 007400AA
W 304 01 00000880 00000000
R 304 00 00000000 00000880
I 000 00 00000880 00000001
A 000 00 00000500 00000000
R 342 00 00000000 8000000B
R 341 00 00000000 00000500
R 300 00 00000000 007400A2
P 000 00 00000000 00000003
I 000 00 00000000 00000000

//--- sim.f
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_counters.sv
hw/csr_machine_regs.sv
hw/csr_bank.sv
sim/tb_clock_gen.sv
sim/csr_bank_props.sv
sim/csr_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR bank testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module csr_bank_tb -o csr_bank_sim
./obj_dir/csr_bank_sim
